// File: verilog/mem_access_pkg.sv
package mem_access_pkg;

    typedef enum logic [1:0] {
        MEM_SIZE_B = 2'b00,
        MEM_SIZE_H = 2'b01,
        MEM_SIZE_W = 2'b10
    } mem_size_t;

    typedef logic [11:0] addr_t;  // Byte address into 4 KiB
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  row_t;   // Word row inside one lane bank

    // One load or store as issued by the LSU
    typedef struct packed {
        logic      write_en;
        addr_t     addr;
        data_t     write_data;
        mem_size_t size;
        logic      sign;        // Sign-extend on load
    } mem_req_t;

    // Per-bank write command after alignment
    typedef struct packed {
        logic  we;
        row_t  row;
        byte_t wdata;
    } lane_wr_t;

endpackage

// File: verilog/dmem_geom_pkg.sv
package dmem_geom_pkg;

    localparam int NUM_LANES      = 4;     // Bytes per RV32 word
    localparam int BANK_DEPTH     = 1024;  // Rows per lane bank
    localparam int ACCESS_LATENCY = 4;     // Edges from accept to resp_valid

endpackage

// File: verilog/dmem_access_ctrl.sv
`timescale 1ns/1ps

module dmem_access_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  mem_access_pkg::mem_req_t req,
    output logic                   wr_strobe,
    output logic                   rd_strobe,
    output logic                   resp_valid
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RESPOND
    } state_t;

    state_t state;
    logic [$clog2(dmem_geom_pkg::ACCESS_LATENCY)-1:0] lat_cnt;
    logic accept;

    // Response cycle counts as rest, so a held request is not taken twice
    assign accept    = (state == IDLE) && req_valid && !resp_valid;
    assign wr_strobe = accept && req.write_en;          // Commit at the accepting edge
    assign rd_strobe = (state == BUSY) && (lat_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            lat_cnt    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= BUSY;
                        lat_cnt <= $bits(lat_cnt)'(dmem_geom_pkg::ACCESS_LATENCY - 1);
                    end
                end
                BUSY: begin
                    if (lat_cnt == '0) begin
                        state      <= RESPOND;
                        resp_valid <= 1'b1;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Banks read the request's row late, so it must not move mid-access
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == BUSY) |-> $stable(req))
        else $error("request changed while access was in flight");

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held for more than one cycle");

endmodule

// File: verilog/store_lane_aligner.sv
`timescale 1ns/1ps

module store_lane_aligner (
    input  mem_access_pkg::mem_req_t                                  req,
    output mem_access_pkg::lane_wr_t [dmem_geom_pkg::NUM_LANES-1:0] lanes
);

    logic [1:0]                offset;
    mem_access_pkg::row_t      base_row;
    mem_access_pkg::row_t      next_row;
    logic [2:0]                nbytes;

    assign offset   = req.addr[1:0];
    assign base_row = req.addr[11:2];
    assign next_row = base_row + 1'b1;  // Wraps to row 0 at the top

    always_comb begin
        case (req.size)
            mem_access_pkg::MEM_SIZE_B: nbytes = 3'd1;
            mem_access_pkg::MEM_SIZE_H: nbytes = 3'd2;
            mem_access_pkg::MEM_SIZE_W: nbytes = 3'd4;
            default:                    nbytes = 3'd0;
        endcase
    end

    for (genvar i = 0; i < dmem_geom_pkg::NUM_LANES; i++) begin : lane_gen
        logic [1:0] k;  // Byte index of the store data that lands in this lane

        assign k = 2'(i) - offset;

        assign lanes[i].we    = req.write_en && ({1'b0, k} < nbytes);
        // Lanes below the offset belong to the next word
        assign lanes[i].row   = (2'(i) < offset) ? next_row : base_row;
        assign lanes[i].wdata = req.write_data[8*k +: 8];
    end

    always_comb begin
        assert (req.size !== 2'b11)
            else $error("access size uses the reserved encoding");
    end

endmodule

// File: verilog/byte_lane_bank.sv
`timescale 1ns/1ps

module byte_lane_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_strobe,
    input  logic                     rd_strobe,
    input  mem_access_pkg::lane_wr_t lane,
    output mem_access_pkg::byte_t    rdata
);

    mem_access_pkg::byte_t mem [dmem_geom_pkg::BANK_DEPTH];

    // Whole bank comes out of reset as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < dmem_geom_pkg::BANK_DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else if (wr_strobe && lane.we) begin
            mem[lane.row] <= lane.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_strobe) begin
            rdata <= mem[lane.row];  // Lands on the resp_valid edge
        end
    end

endmodule

// File: verilog/load_extender.sv
`timescale 1ns/1ps

module load_extender (
    input  mem_access_pkg::byte_t [dmem_geom_pkg::NUM_LANES-1:0] lane_data,
    input  logic [1:0]                                          offset,
    input  mem_access_pkg::mem_size_t                           size,
    input  logic                                                sign,
    output mem_access_pkg::data_t                               read_data
);

    mem_access_pkg::data_t aligned;  // Lane bytes back in address order

    for (genvar k = 0; k < dmem_geom_pkg::NUM_LANES; k++) begin : byte_gen
        assign aligned[8*k +: 8] = lane_data[2'(k) + offset];
    end

    always_comb begin
        case (size)
            mem_access_pkg::MEM_SIZE_B: begin
                if (sign) begin
                    read_data = {{24{aligned[7]}}, aligned[7:0]};
                end else begin
                    read_data = {24'b0, aligned[7:0]};
                end
            end
            mem_access_pkg::MEM_SIZE_H: begin
                if (sign) begin
                    read_data = {{16{aligned[15]}}, aligned[15:0]};
                end else begin
                    read_data = {16'b0, aligned[15:0]};
                end
            end
            mem_access_pkg::MEM_SIZE_W: read_data = aligned;  // Sign has no effect
            default:                    read_data = '0;
        endcase
    end

endmodule

// File: verilog/dmem.sv
`timescale 1ns/1ps

module dmem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  mem_access_pkg::mem_req_t req,
    output logic                     resp_valid,
    output mem_access_pkg::data_t    read_data
);

    logic wr_strobe;
    logic rd_strobe;

    mem_access_pkg::lane_wr_t [dmem_geom_pkg::NUM_LANES-1:0] lanes;
    mem_access_pkg::byte_t    [dmem_geom_pkg::NUM_LANES-1:0] lane_rdata;

    dmem_access_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .wr_strobe  (wr_strobe),
        .rd_strobe  (rd_strobe),
        .resp_valid (resp_valid)
    );

    store_lane_aligner u_aligner (
        .req   (req),
        .lanes (lanes)
    );

    // One bank per byte lane, little-endian
    for (genvar i = 0; i < dmem_geom_pkg::NUM_LANES; i++) begin : lane_gen
        byte_lane_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_strobe (wr_strobe),
            .rd_strobe (rd_strobe),
            .lane      (lanes[i]),
            .rdata     (lane_rdata[i])
        );
    end

    // Request is still held while resp_valid is high
    load_extender u_extender (
        .lane_data (lane_rdata),
        .offset    (req.addr[1:0]),
        .size      (req.size),
        .sign      (req.sign),
        .read_data (read_data)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: sim/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb;

    localparam int MAX_CYCLES = 2500;  // About 300 accesses at 6 cycles plus reset
    localparam int RESP_EDGES = 5;     // One edge to accept, then four edges of latency
    localparam int MEM_BYTES  = 4096;

    localparam mem_access_pkg::mem_size_t SZ_B = mem_access_pkg::MEM_SIZE_B;
    localparam mem_access_pkg::mem_size_t SZ_H = mem_access_pkg::MEM_SIZE_H;
    localparam mem_access_pkg::mem_size_t SZ_W = mem_access_pkg::MEM_SIZE_W;

    logic                     clk;
    logic                     rst_n;
    logic                     req_valid;
    mem_access_pkg::mem_req_t req;
    logic                     resp_valid;
    mem_access_pkg::data_t    read_data;

    mem_access_pkg::byte_t ref_mem [MEM_BYTES];  // Byte-addressed reference model
    mem_access_pkg::data_t exp_data;
    logic                  exp_load;
    logic                  pending;
    logic [31:0]           lcg_state;
    int                    errors       = 0;
    int                    test_errors  = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    cycles       = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dmem dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .read_data  (read_data)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // Upper bits have the longer period
    endfunction

    function automatic int size_bytes(input mem_access_pkg::mem_size_t size);
        case (size)
            mem_access_pkg::MEM_SIZE_B: return 1;
            mem_access_pkg::MEM_SIZE_H: return 2;
            default:                    return 4;
        endcase
    endfunction

    // Little-endian with byte addresses wrapping at the top of memory
    function automatic mem_access_pkg::data_t model_read(input mem_access_pkg::mem_req_t r);
        mem_access_pkg::data_t value;
        mem_access_pkg::addr_t a;
        int n;
        n = size_bytes(r.size);
        value = '0;
        for (int k = 0; k < n; k++) begin
            a = r.addr + mem_access_pkg::addr_t'(k);
            value[8*k +: 8] = ref_mem[a];
        end
        if (r.sign && n < 4 && value[8*n-1]) begin
            for (int k = n; k < 4; k++) begin
                value[8*k +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    function automatic void model_write(input mem_access_pkg::mem_req_t r);
        mem_access_pkg::addr_t a;
        for (int k = 0; k < size_bytes(r.size); k++) begin
            a = r.addr + mem_access_pkg::addr_t'(k);
            ref_mem[a] = r.write_data[8*k +: 8];
        end
    endfunction

    function automatic mem_access_pkg::mem_req_t make_req(
        input logic                      we,
        input mem_access_pkg::addr_t     addr,
        input mem_access_pkg::data_t     data,
        input mem_access_pkg::mem_size_t size,
        input logic                      sign
    );
        mem_access_pkg::mem_req_t r;
        r.write_en   = we;
        r.addr       = addr;
        r.write_data = data;
        r.size       = size;
        r.sign       = sign;
        return r;
    endfunction

    // Issue on a rising edge and watch for the response on falling edges
    task automatic run_access(input mem_access_pkg::mem_req_t r);
        int waited;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        pending  = 1'b1;
        exp_load = !r.write_en;
        if (r.write_en) begin
            model_write(r);
        end else begin
            exp_data = model_read(r);
        end
        waited = 0;
        @(negedge clk);
        while (!resp_valid && waited <= RESP_EDGES) begin
            @(negedge clk);
            waited++;
        end
        pending = 1'b0;
        assert (resp_valid && waited == RESP_EDGES)
            else begin
                $display("response missing or late: %0d edges, expected %0d (addr %h)",
                         waited, RESP_EDGES, r.addr);
                errors++;
            end
    endtask

    task automatic store_at(input mem_access_pkg::addr_t addr, input mem_access_pkg::data_t data,
                            input mem_access_pkg::mem_size_t size);
        run_access(make_req(1'b1, addr, data, size, 1'b0));
    endtask

    task automatic load_from(input mem_access_pkg::addr_t addr,
                             input mem_access_pkg::mem_size_t size, input logic sign);
        run_access(make_req(1'b0, addr, '0, size, sign));
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        req_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    a_read_data: assert property (@(negedge clk) disable iff (!rst_n)
        (resp_valid && exp_load) |-> (read_data == exp_data))
        else begin
            $display("MISMATCH read_data expected %h actual %h (addr %h)",
                     exp_data, read_data, req.addr);
            errors++;
        end

    a_resp_pulse: assert property (@(negedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else begin
            $display("resp_valid stayed high for more than one cycle");
            errors++;
        end

    // A second acceptance of a held request would show up here
    a_resp_expected: assert property (@(negedge clk) disable iff (!rst_n)
        resp_valid |-> pending)
        else begin
            $display("resp_valid raised with no request outstanding");
            errors++;
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        logic [15:0]               r_hi;
        logic [15:0]               r_lo;
        mem_access_pkg::addr_t     r_addr;
        mem_access_pkg::mem_size_t r_size;
        mem_access_pkg::addr_t     base;
        req_valid = 1'b0;
        req       = '0;
        exp_data  = '0;
        exp_load  = 1'b0;
        pending   = 1'b0;
        lcg_state = 32'd29035;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[a] = '0;
        end

        @(posedge rst_n);
        @(negedge clk);
        assert (resp_valid == 1'b0)
            else begin
                $display("resp_valid high after reset");
                errors++;
            end
        for (int i = 0; i < 4; i++) begin
            load_from(mem_access_pkg::addr_t'(lcg_next()), SZ_W, 1'b0);
        end
        finish_test("reset");

        // Back to back with each request held through the previous response
        load_from(12'h010, SZ_W, 1'b0);
        load_from(12'h020, SZ_H, 1'b0);
        load_from(12'h030, SZ_B, 1'b0);
        idle_cycles(8);
        finish_test("latency");

        store_at(12'h100, 32'h0123_4567, SZ_W);
        store_at(12'h104, 32'h89ab_cdef, SZ_W);
        store_at(12'h108, 32'hdead_beef, SZ_W);
        store_at(12'hffc, 32'h0000_00ff, SZ_W);
        for (int i = 0; i < 3; i++) begin
            load_from(12'h100 + mem_access_pkg::addr_t'(4*i), SZ_W, 1'b0);
            for (int b = 0; b < 4; b++) begin
                load_from(12'h100 + mem_access_pkg::addr_t'(4*i + b), SZ_B, 1'b0);
            end
        end
        load_from(12'hffc, SZ_W, 1'b1);
        finish_test("aligned word");

        store_at(12'h200, 32'h80ff_7f01, SZ_W);
        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < 4; b++) begin
                load_from(12'h200 + mem_access_pkg::addr_t'(b), SZ_B, 1'(s));
            end
            load_from(12'h200, SZ_H, 1'(s));
            load_from(12'h202, SZ_H, 1'(s));
            load_from(12'h200, SZ_W, 1'(s));
        end
        finish_test("sign extension");

        for (int off = 1; off < 4; off++) begin
            base = 12'h400 + mem_access_pkg::addr_t'(17 * off);
            store_at(base, 32'h0000_a55a + 32'(off), SZ_H);
            store_at(base + 12'd4, 32'hc3d2_e1f0 ^ 32'(off), SZ_W);  // Crosses into next row
            load_from(base, SZ_H, 1'b1);
            load_from(base + 12'd4, SZ_W, 1'b0);
            load_from(base + 12'd3, SZ_H, 1'b0);
        end
        store_at(12'd4094, 32'h7654_3210, SZ_W);  // Upper half lands at address 0
        load_from(12'd4094, SZ_W, 1'b0);
        load_from(12'h000, SZ_W, 1'b0);
        store_at(12'd4095, 32'h0000_9c81, SZ_H);
        load_from(12'd4095, SZ_H, 1'b1);
        load_from(12'h000, SZ_B, 1'b1);
        finish_test("misaligned");

        for (int i = 0; i < 200; i++) begin
            r_hi   = lcg_next();
            r_lo   = lcg_next();
            r_addr = mem_access_pkg::addr_t'(lcg_next());
            r_size = mem_access_pkg::mem_size_t'(2'(lcg_next() % 3));
            run_access(make_req(r_hi[15], r_addr, {r_hi, r_lo}, r_size, r_lo[0]));
        end
        finish_test("random");

        idle_cycles(2);
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/mem_access_pkg.sv
verilog/dmem_geom_pkg.sv
verilog/dmem_access_ctrl.sv
verilog/store_lane_aligner.sv
verilog/byte_lane_bank.sv
verilog/load_extender.sv
verilog/dmem.sv
sim/tb_clock_gen.sv
sim/dmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dmem_tb \
    -f project.f -o dmem_sim > build.log 2>&1 \
    || { cat build.log; echo "build error, see build.log"; exit 1; }
./obj_dir/dmem_sim > sim.log 2>&1
cat sim.log
grep -q "sim passed" sim.log && ! grep -q "sim failed" sim.log \
    && echo "result: PASS" \
    || { echo "result: FAIL"; exit 1; }
